//--- include/core_settings.svh
//////////////////////////////
// widths, register count and opcodes of the integer pipeline
// included by the package and by every RTL module that needs them
//////////////////////////////

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

//////////////////////////////
// datapath sizes
//////////////////////////////

`define XLEN       32     // data word width
`define REG_IDX_W  5      // register index width
`define REG_COUNT  32     // architectural registers
`define ZERO_REG   0      // hardwired zero register

//////////////////////////////
// RV32 encodings
//////////////////////////////

`define OPCODE_OP      7'b0110011   // register-register ops
`define OPCODE_OP_IMM  7'b0010011   // register-immediate ops
`define FUNCT7_ALT     7'b0100000   // picks SUB over ADD

`endif

//--- source/core_pkg.sv
//////////////////////////////
// shared types of the pipeline
// instruction views and the ALU operation code
//////////////////////////////

`include "core_settings.svh"

package core_pkg;

    //////////////////////////////
    // instruction formats
    //////////////////////////////

    // register-register layout
    typedef struct packed {
        logic [6:0]            funct7;  // SUB select lives here
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    // register-immediate layout
    typedef struct packed {
        logic [11:0]           imm;     // signed, extended in decode
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    // one 32-bit word, two readings
    // opcode, rd and rs1 sit at the same bits in both
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_t;

    //////////////////////////////
    // ALU operations
    //////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5   // signed set-less-than
    } alu_op_t;

endpackage

//--- source/register_file.sv
//////////////////////////////
// architectural register file, 2 read ports and 1 write port
// reads see a same-cycle write, x0 always reads zero
//////////////////////////////

`timescale 1ns/10ps

`include "core_settings.svh"

module register_file (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`REG_IDX_W-1:0] rd_idx_a,
    input  logic [`REG_IDX_W-1:0] rd_idx_b,
    output logic [`XLEN-1:0]      rd_data_a,
    output logic [`XLEN-1:0]      rd_data_b,
    input  logic                  wr_en,
    input  logic [`REG_IDX_W-1:0] wr_idx,
    input  logic [`XLEN-1:0]      wr_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wr_live;   // write that actually lands

    assign wr_live = wr_en && (wr_idx != `ZERO_REG);

    // storage, all cleared by reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // read port a, write-through bypass
    always_comb begin
        if (rd_idx_a == `ZERO_REG)                rd_data_a = '0;
        else if (wr_live && wr_idx == rd_idx_a)   rd_data_a = wr_data;   // newest value
        else                                      rd_data_a = regs[rd_idx_a];
    end

    // read port b, same rules
    always_comb begin
        if (rd_idx_b == `ZERO_REG)                rd_data_b = '0;
        else if (wr_live && wr_idx == rd_idx_b)   rd_data_b = wr_data;
        else                                      rd_data_b = regs[rd_idx_b];
    end

endmodule

//--- source/alu.sv
//////////////////////////////
// integer ALU for the EX stage, purely combinational
//////////////////////////////

`timescale 1ns/10ps

`include "core_settings.svh"

module alu import core_pkg::*; (
    input  alu_op_t          op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] result
);

    logic less;   // signed a < b

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(`XLEN-1){1'b0}}, less};   // 1 or 0
            default: result = '0;                          // unused codes
        endcase
    end

endmodule

//--- source/decode_stage.sv
//////////////////////////////
// ID stage, decodes one instruction word and picks its operands
// ends in the ID/EX register, which moves only on advance
//////////////////////////////

`timescale 1ns/10ps

`include "core_settings.svh"

module decode_stage import core_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  inst_t                 inst_data,
    input  logic                  advance,
    // register file reads
    output logic [`REG_IDX_W-1:0] rs1_idx,
    output logic [`REG_IDX_W-1:0] rs2_idx,
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      rs2_data,
    // result of the instruction now in EX
    input  logic                  ex_fwd_en,
    input  logic [`REG_IDX_W-1:0] ex_fwd_rd,
    input  logic [`XLEN-1:0]      ex_fwd_data,
    // ID/EX register
    output logic                  ex_valid,
    output logic                  ex_illegal,
    output logic                  ex_use_imm,
    output alu_op_t               ex_alu_op,
    output logic [`REG_IDX_W-1:0] ex_rd,
    output logic [`XLEN-1:0]      ex_opa,
    output logic [`XLEN-1:0]      ex_opb,
    output logic [`XLEN-1:0]      ex_imm
);

    alu_op_t          alu_op;
    logic             illegal;
    logic             use_imm;
    logic [`XLEN-1:0] imm;
    logic             fwd_a, fwd_b;
    logic [`XLEN-1:0] opa, opb;

    // rs2 bits are part of imm in the I view, unused there
    assign rs1_idx = inst_data.r.rs1;
    assign rs2_idx = inst_data.r.rs2;
    assign imm     = {{(`XLEN-12){inst_data.i.imm[11]}}, inst_data.i.imm};  // sign extend

    //////////////////////////////
    // opcode and function decode
    //////////////////////////////

    always_comb begin
        alu_op  = ALU_ADD;
        illegal = 1'b0;
        use_imm = 1'b0;
        case (inst_data.r.opcode)
            `OPCODE_OP: begin
                if (inst_data.r.funct7 == `FUNCT7_ALT) begin
                    // only SUB uses the alternate funct7
                    if (inst_data.r.funct3 == 3'b000) alu_op = ALU_SUB;
                    else                              illegal = 1'b1;
                end else if (inst_data.r.funct7 == 7'b0000000) begin
                    case (inst_data.r.funct3)
                        3'b000:  alu_op = ALU_ADD;
                        3'b010:  alu_op = ALU_SLT;
                        3'b100:  alu_op = ALU_XOR;
                        3'b110:  alu_op = ALU_OR;
                        3'b111:  alu_op = ALU_AND;
                        default: illegal = 1'b1;   // shifts, sltu
                    endcase
                end else begin
                    illegal = 1'b1;                // undefined funct7
                end
            end
            `OPCODE_OP_IMM: begin
                use_imm = 1'b1;
                case (inst_data.i.funct3)
                    3'b000:  alu_op = ALU_ADD;     // addi
                    3'b100:  alu_op = ALU_XOR;     // xori
                    3'b110:  alu_op = ALU_OR;      // ori
                    3'b111:  alu_op = ALU_AND;     // andi
                    default: illegal = 1'b1;       // slti, shifts not kept
                endcase
            end
            default: illegal = 1'b1;               // any other opcode
        endcase
    end

    //////////////////////////////
    // operand forwarding
    //////////////////////////////

    // EX result beats the register file, x0 never forwarded
    assign fwd_a = ex_fwd_en && (ex_fwd_rd == rs1_idx) && (rs1_idx != `ZERO_REG);
    assign fwd_b = ex_fwd_en && (ex_fwd_rd == rs2_idx) && (rs2_idx != `ZERO_REG);

    assign opa = fwd_a ? ex_fwd_data : rs1_data;
    assign opb = fwd_b ? ex_fwd_data : rs2_data;

    //////////////////////////////
    // ID/EX register
    //////////////////////////////

    // control bits
    always_ff @(posedge clock) begin
        if (reset) begin
            ex_valid   <= 1'b0;
            ex_illegal <= 1'b0;
        end else if (advance) begin
            ex_valid   <= inst_valid;   // bubble when nothing offered
            ex_illegal <= illegal;
        end
    end

    // payload
    always_ff @(posedge clock) begin
        if (advance) begin
            ex_use_imm <= use_imm;
            ex_alu_op  <= alu_op;
            ex_rd      <= inst_data.r.rd;
            ex_opa     <= opa;
            ex_opb     <= opb;
            ex_imm     <= imm;
        end
    end

endmodule

//--- source/execute_stage.sv
//////////////////////////////
// EX stage and the EX/WB register
// drives the commit stream, the register write and the advance signal
//////////////////////////////

`timescale 1ns/10ps

`include "core_settings.svh"

module execute_stage import core_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    // ID/EX register
    input  logic                  ex_valid,
    input  logic                  ex_illegal,
    input  logic                  ex_use_imm,
    input  alu_op_t               ex_alu_op,
    input  logic [`REG_IDX_W-1:0] ex_rd,
    input  logic [`XLEN-1:0]      ex_opa,
    input  logic [`XLEN-1:0]      ex_opb,
    input  logic [`XLEN-1:0]      ex_imm,
    input  logic                  commit_ready,
    output logic                  advance,
    // back to decode
    output logic                  ex_fwd_en,
    output logic [`REG_IDX_W-1:0] ex_fwd_rd,
    output logic [`XLEN-1:0]      ex_fwd_data,
    // commit stream, also the register write port
    output logic                  commit_valid,
    output logic                  commit_wr_en,
    output logic [`REG_IDX_W-1:0] commit_rd,
    output logic [`XLEN-1:0]      commit_data,
    output logic                  commit_illegal
);

    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] result;
    logic             writes;   // legal op with a real rd

    assign alu_b = ex_use_imm ? ex_imm : ex_opb;

    alu u_alu (
        .op     (ex_alu_op),
        .a      (ex_opa),
        .b      (alu_b),
        .result (result)
    );

    assign writes = ex_valid && !ex_illegal && (ex_rd != `ZERO_REG);

    // forward path into decode
    assign ex_fwd_en   = writes;
    assign ex_fwd_rd   = ex_rd;
    assign ex_fwd_data = result;

    // whole pipe moves when WB is empty or draining
    assign advance = !commit_valid || commit_ready;

    //////////////////////////////
    // EX/WB register
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid   <= 1'b0;
            commit_wr_en   <= 1'b0;
            commit_illegal <= 1'b0;
        end else if (advance) begin
            commit_valid   <= ex_valid;
            commit_wr_en   <= writes;
            commit_illegal <= ex_valid && ex_illegal;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            commit_rd   <= ex_rd;
            commit_data <= ex_illegal ? '0 : result;   // illegal carries no data
        end
    end

endmodule

//--- source/core_top.sv
//////////////////////////////
// top of the ID/EX/WB integer pipeline
// instruction stream in, commit stream out, both valid/ready
//////////////////////////////

`timescale 1ns/10ps

`include "core_settings.svh"

module core_top import core_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  logic [31:0]           inst_data,
    output logic                  inst_ready,
    output logic                  commit_valid,
    output logic                  commit_wr_en,
    output logic                  commit_illegal,
    output logic [`REG_IDX_W-1:0] commit_rd,
    output logic [`XLEN-1:0]      commit_data,
    input  logic                  commit_ready
);

    //////////////////////////////
    // stage wires
    //////////////////////////////

    logic                  advance;
    logic [`REG_IDX_W-1:0] rs1_idx, rs2_idx;
    logic [`XLEN-1:0]      rs1_data, rs2_data;
    logic                  ex_fwd_en;
    logic [`REG_IDX_W-1:0] ex_fwd_rd;
    logic [`XLEN-1:0]      ex_fwd_data;
    logic                  ex_valid, ex_illegal, ex_use_imm;
    alu_op_t               ex_alu_op;
    logic [`REG_IDX_W-1:0] ex_rd;
    logic [`XLEN-1:0]      ex_opa, ex_opb, ex_imm;

    assign inst_ready = advance;   // accept whenever the pipe moves

    register_file u_register_file (
        .clock     (clock),
        .reset     (reset),
        .rd_idx_a  (rs1_idx),
        .rd_idx_b  (rs2_idx),
        .rd_data_a (rs1_data),
        .rd_data_b (rs2_data),
        .wr_en     (commit_wr_en),   // WB write, seen by decode same cycle
        .wr_idx    (commit_rd),
        .wr_data   (commit_data)
    );

    decode_stage u_decode_stage (
        .clock       (clock),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst_data   (inst_data),
        .advance     (advance),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_fwd_en   (ex_fwd_en),
        .ex_fwd_rd   (ex_fwd_rd),
        .ex_fwd_data (ex_fwd_data),
        .ex_valid    (ex_valid),
        .ex_illegal  (ex_illegal),
        .ex_use_imm  (ex_use_imm),
        .ex_alu_op   (ex_alu_op),
        .ex_rd       (ex_rd),
        .ex_opa      (ex_opa),
        .ex_opb      (ex_opb),
        .ex_imm      (ex_imm)
    );

    execute_stage u_execute_stage (
        .clock          (clock),
        .reset          (reset),
        .ex_valid       (ex_valid),
        .ex_illegal     (ex_illegal),
        .ex_use_imm     (ex_use_imm),
        .ex_alu_op      (ex_alu_op),
        .ex_rd          (ex_rd),
        .ex_opa         (ex_opa),
        .ex_opb         (ex_opb),
        .ex_imm         (ex_imm),
        .commit_ready   (commit_ready),
        .advance        (advance),
        .ex_fwd_en      (ex_fwd_en),
        .ex_fwd_rd      (ex_fwd_rd),
        .ex_fwd_data    (ex_fwd_data),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_illegal (commit_illegal)
    );

endmodule

//--- tests/core_tb.sv
//////////////////////////////
// testbench for the ID/EX/WB core
// streams instructions in, models the registers, checks each commit
//////////////////////////////

`timescale 1ns/10ps

`include "core_settings.svh"

module core_tb;

    localparam logic [31:0] SEED = 32'h9c337428;
    localparam int N_BASIC   = 1;
    localparam int N_RANDOM  = 115;   // 15 setup writes and 100 random ops
    localparam int N_CHAIN   = 40;
    localparam int N_ZERO    = 20;
    localparam int N_STALL   = 150;
    localparam int N_ILLEGAL = 51;    // 20 bad words and 31 read-backs
    localparam int CYCLE_LIMIT =
        4 * (N_BASIC + N_RANDOM + N_CHAIN + N_ZERO + N_STALL + N_ILLEGAL) + 200;

    logic        clock, reset;
    logic        inst_valid, inst_ready;
    logic [31:0] inst_data;
    logic        commit_valid, commit_wr_en, commit_illegal, commit_ready;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    logic [31:0] model_regs [32];       // reference register file
    logic [31:0] stim_q [$];            // words not yet accepted
    logic [38:0] exp_q [$];             // {illegal, wr_en, rd, data}
    logic [31:0] rng_state = SEED;
    logic [31:0] ready_state = ~SEED;   // separate stream for commit_ready
    logic        stall_mode = 1'b0;
    logic        reset_checked = 1'b0;
    int          error_count = 0;
    int          check_count = 0;
    int          errors_at_start = 0;
    int          tests_failed = 0;
    int          test_index = 0;
    int          cycle_count = 0;

    core_top u_dut (
        .clock          (clock),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst_data      (inst_data),
        .inst_ready     (inst_ready),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_illegal (commit_illegal),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_ready   (commit_ready)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;   // 100 ns period
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPCODE_OP};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPCODE_OP_IMM};
    endfunction

    // one of the ten kept operations with a random immediate
    function automatic logic [31:0] random_op(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        logic [31:0] r;
        r = next_random();
        case (r % 10)
            0:       return encode_r(7'h00, rs2, rs1, 3'b000, rd);         // add
            1:       return encode_r(`FUNCT7_ALT, rs2, rs1, 3'b000, rd);   // sub
            2:       return encode_r(7'h00, rs2, rs1, 3'b111, rd);         // and
            3:       return encode_r(7'h00, rs2, rs1, 3'b110, rd);         // or
            4:       return encode_r(7'h00, rs2, rs1, 3'b100, rd);         // xor
            5:       return encode_r(7'h00, rs2, rs1, 3'b010, rd);         // slt
            6:       return encode_i(r[31:20], rs1, 3'b000, rd);           // addi
            7:       return encode_i(r[31:20], rs1, 3'b111, rd);           // andi
            8:       return encode_i(r[31:20], rs1, 3'b110, rd);           // ori
            default: return encode_i(r[31:20], rs1, 3'b100, rd);           // xori
        endcase
    endfunction

    // words outside the kept set
    function automatic logic [31:0] random_illegal();
        logic [31:0] r;
        logic [2:0]  f3;
        r = next_random();
        case (r[1:0])
            2'd0: begin   // foreign opcode
                r = next_random();   // opcode drawn over all 7 bits
                if (r[6:0] == `OPCODE_OP || r[6:0] == `OPCODE_OP_IMM) r[2] = ~r[2];
                return r;
            end
            2'd1: begin   // undefined funct7
                if (r[31:25] == 7'h00 || r[31:25] == `FUNCT7_ALT) r[25] = 1'b1;
                return {r[31:7], `OPCODE_OP};
            end
            2'd2: return encode_r(`FUNCT7_ALT, r[24:20], r[19:15], r[14:12] | 3'b001, r[11:7]);
            default: begin   // slti, sltiu and shifts are not kept
                case (r[13:12])
                    2'd0:    f3 = 3'b001;
                    2'd1:    f3 = 3'b010;
                    2'd2:    f3 = 3'b011;
                    default: f3 = 3'b101;
                endcase
                return encode_i(r[31:20], r[19:15], f3, r[11:7]);
            end
        endcase
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [38:0] reference_exec(input logic [31:0] w);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a, b, imm, res;
        logic        legal, wr;
        rd    = w[11:7];
        f3    = w[14:12];
        f7    = w[31:25];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm   = {{20{w[31]}}, w[31:20]};   // sign extended
        legal = 1'b1;
        res   = '0;
        if (w[6:0] == `OPCODE_OP && f7 == 7'h00) begin
            case (f3)
                3'b000:  res = a + b;
                3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100:  res = a ^ b;
                3'b110:  res = a | b;
                3'b111:  res = a & b;
                default: legal = 1'b0;
            endcase
        end else if (w[6:0] == `OPCODE_OP && f7 == `FUNCT7_ALT && f3 == 3'b000) begin
            res = a - b;
        end else if (w[6:0] == `OPCODE_OP_IMM) begin
            case (f3)
                3'b000:  res = a + imm;
                3'b100:  res = a ^ imm;
                3'b110:  res = a | imm;
                3'b111:  res = a & imm;
                default: legal = 1'b0;
            endcase
        end else begin
            legal = 1'b0;
        end
        wr = legal && (rd != 5'd0);   // x0 stays zero
        if (wr) model_regs[rd] = res;
        if (!legal) res = '0;
        return {!legal, wr, rd, res};
    endfunction

    task automatic queue_inst(input logic [31:0] word);
        stim_q.push_back(word);
        exp_q.push_back(reference_exec(word));
    endtask

    // hold each word until the edge that takes it
    task automatic feed_stream();
        while (stim_q.size() > 0) begin
            inst_valid <= 1'b1;
            inst_data  <= stim_q[0];
            @(posedge clock);
            while (!inst_ready) begin
                @(posedge clock);
            end
            stim_q.delete(0);
        end
        inst_valid <= 1'b0;
    endtask

    task automatic run_and_report(input string name);
        int errs;
        @(posedge clock);
        feed_stream();
        while (exp_q.size() != 0) begin
            @(posedge clock);
        end
        errs = error_count - errors_at_start;
        test_index++;
        if (errs != 0) tests_failed++;
        $display("test %0d, %s: %s, %0d errors", test_index, name, errs == 0 ? "ok" : "FAILED",
                 errs);
        errors_at_start = error_count;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        check_count++;
        assert (got === want) else begin
            $display("error %s got %h expected %h", name, got, want);
            error_count++;
        end
    endtask

    //////////////////////////////
    // commit checker
    //////////////////////////////

    always @(posedge clock) begin : compare
        logic [38:0] expected;
        if (!reset) begin
            if (!reset_checked) begin   // first edge out of reset
                check_value("commit_valid", 32'(commit_valid), 32'd0);
                check_value("inst_ready", 32'(inst_ready), 32'd1);
                reset_checked = 1'b1;
            end
            if (commit_valid && !commit_ready) check_value("inst_ready", 32'(inst_ready), 32'd0);
            if (commit_valid && commit_ready) begin
                check_count++;
                assert (exp_q.size() > 0) else begin
                    $display("a commit fired with no instruction outstanding");
                    error_count++;
                end
                if (exp_q.size() > 0) begin
                    expected = exp_q.pop_front();
                    check_value("commit_illegal", 32'(commit_illegal), 32'(expected[38]));
                    check_value("commit_wr_en", 32'(commit_wr_en), 32'(expected[37]));
                    check_value("commit_rd", 32'(commit_rd), 32'(expected[36:32]));
                    if (!expected[38]) check_value("commit_data", commit_data, expected[31:0]);
                end
            end
        end
    end

    // about half the cycles ready when stalling
    initial begin
        commit_ready = 1'b1;
        forever begin
            @(posedge clock);
            ready_state = xorshift(ready_state);
            commit_ready <= stall_mode ? ready_state[9] : 1'b1;
        end
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("run timed out after %0d cycles, %0d commits still expected", cycle_count,
                 exp_q.size());
        $display("test failed");
        $finish;
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        logic [31:0] rv;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst_data  = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        queue_inst(encode_i(12'h5a3, 5'd0, 3'b000, 5'd1));   // addi x1, x0
        run_and_report("reset state and first addi");

        for (int k = 1; k < 16; k++) begin   // seed x1..x15
            rv = next_random();
            queue_inst(encode_i(rv[11:0], 5'd0, 3'b000, 5'(k)));
        end
        for (int k = 0; k < 100; k++) begin   // sources in x1..x15 and targets in x16..x31
            rv = next_random();
            queue_inst(random_op(5'd16 + 5'(rv[3:0]), 5'd1 + 5'(rv[7:4] % 15),
                                 5'd1 + 5'(rv[11:8] % 15)));
        end
        run_and_report("independent random ops");

        for (int k = 0; k < 20; k++) begin   // distance one through the EX forward
            queue_inst(random_op(5'd5, 5'd5, 5'(k % 16)));
        end
        for (int k = 0; k < 20; k++) begin   // distance two through write-through
            queue_inst(random_op(k[0] ? 5'd7 : 5'd6, k[0] ? 5'd7 : 5'd6, k[0] ? 5'd6 : 5'd7));
        end
        run_and_report("dependent chains");

        for (int k = 0; k < 10; k++) begin
            rv = next_random();
            queue_inst(random_op(5'd0, rv[4:0], rv[9:5]));
            queue_inst(encode_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd8));   // or x8, x0, x0
        end
        run_and_report("writes to x0");

        stall_mode = 1'b1;
        for (int k = 0; k < N_STALL; k++) begin
            rv = next_random();
            if (rv[31:28] < 4'd2) queue_inst(random_illegal());   // one in eight
            else queue_inst(random_op(rv[4:0], rv[9:5], rv[14:10]));
        end
        run_and_report("back-pressure");
        stall_mode = 1'b0;

        for (int k = 0; k < 20; k++) begin
            queue_inst(random_illegal());
        end
        for (int k = 1; k < 32; k++) begin   // or xk, xk, x0 reads back each register
            queue_inst(encode_r(7'h00, 5'd0, 5'(k), 3'b110, 5'(k)));
        end
        run_and_report("illegal words");

        $display("%0d tests, %0d failed, %0d checks, %0d errors", test_index, tests_failed,
                 check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
source/core_pkg.sv
source/register_file.sv
source/alu.sv
source/decode_stage.sv
source/execute_stage.sv
source/core_top.sv
tests/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the core testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module core_tb -f src.f -o core_sim || exit 1
sim_out="$(./obj_dir/core_sim)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "test passed" && echo "simulation ok" || {
    echo "simulation failed"
    exit 1
}
